/* src/core_pkg.sv */
package core_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths and depths
  ////////////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH     = 32;
  localparam int INST_WIDTH     = 32;
  localparam int NUM_REGS       = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int IMM_WIDTH      = 16;
  localparam int SHAMT_WIDTH    = 5;
  localparam int QUEUE_DEPTH    = 4;
  localparam int OUT_CREDITS    = 2;

  // derived counter and pointer widths
  localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
  localparam int OUT_CNT_WIDTH   = $clog2(OUT_CREDITS + 1);

  // instruction field positions
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_MSB  = 10;
  localparam int SHAMT_LSB  = 6;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  ////////////////////////////////////////////////////////////////////
  // shared types
  ////////////////////////////////////////////////////////////////////

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [INST_WIDTH-1:0]     instr_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_PASS_B
  } alu_op_t;

  // values not listed here decode as no-ops
  typedef enum logic [5:0] {
    OP_ADD  = 6'd0, OP_SUB = 6'd1, OP_AND = 6'd2, OP_OR = 6'd3,
    OP_XOR  = 6'd4, OP_SLT = 6'd5, OP_SLL = 6'd6,
    OP_ADDI = 6'd8, OP_ORI = 6'd9, OP_LI  = 6'd10
  } opcode_t;

endpackage

/* src/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  input  core_pkg::instr_t in_instr,
  input  logic             advance,
  output logic             head_valid,
  output core_pkg::instr_t head_instr,
  output logic             in_credit
);
  import core_pkg::*;

  instr_t                     mem [QUEUE_DEPTH];
  logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
  logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
  logic [QUEUE_CNT_WIDTH-1:0] count;
  logic                       push;
  logic                       pop;

  // circular increment, works for any depth
  function automatic logic [QUEUE_PTR_WIDTH-1:0] next_ptr(
    input logic [QUEUE_PTR_WIDTH-1:0] ptr
  );
    if (ptr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign head_valid = (count != '0);
  assign head_instr = mem[rd_ptr];
  assign push       = in_valid && (count != QUEUE_CNT_WIDTH'(QUEUE_DEPTH));
  assign pop        = advance && head_valid;

  // each freed entry goes back upstream as one credit
  assign in_credit = pop;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_instr;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::reg_addr_t rs_addr,
  input  core_pkg::reg_addr_t rt_addr,
  output core_pkg::data_t     rs_data,
  output core_pkg::data_t     rt_data,
  input  logic                wr_en,
  input  core_pkg::reg_addr_t wr_addr,
  input  core_pkg::data_t     wr_data
);
  import core_pkg::*;

  data_t regs [NUM_REGS];
  logic  wr_live;

  // r0 is hardwired, never written
  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through so decode sees the retiring result
  assign rs_data = (wr_live && (wr_addr == rs_addr)) ? wr_data : regs[rs_addr];
  assign rt_data = (wr_live && (wr_addr == rt_addr)) ? wr_data : regs[rt_addr];

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             advance,
  input  logic                             head_valid,
  input  core_pkg::instr_t                 head_instr,
  output core_pkg::reg_addr_t              rs_addr,
  output core_pkg::reg_addr_t              rt_addr,
  input  core_pkg::data_t                  rs_data,
  input  core_pkg::data_t                  rt_data,
  output logic                             id_valid,
  output core_pkg::alu_op_t                id_alu_op,
  output logic                             id_use_imm,
  output logic                             id_write,
  output core_pkg::reg_addr_t              id_rs,
  output core_pkg::reg_addr_t              id_rt,
  output core_pkg::reg_addr_t              id_dest,
  output core_pkg::data_t                  id_op_a,
  output core_pkg::data_t                  id_op_b,
  output core_pkg::data_t                  id_imm,
  output logic [core_pkg::SHAMT_WIDTH-1:0] id_shamt
);
  import core_pkg::*;

  opcode_t   opcode;
  reg_addr_t rd;
  data_t     imm_ext;
  alu_op_t   alu_op;
  logic      use_imm;
  logic      write_en;
  logic      dest_rd;
  reg_addr_t dest;

  // field extraction
  assign opcode  = opcode_t'(head_instr[OPCODE_MSB:OPCODE_LSB]);
  assign rs_addr = head_instr[RS_MSB:RS_LSB];
  assign rt_addr = head_instr[RT_MSB:RT_LSB];
  assign rd      = head_instr[RD_MSB:RD_LSB];
  assign imm_ext = {{(DATA_WIDTH - IMM_WIDTH){1'b0}}, head_instr[IMM_MSB:IMM_LSB]};

  ////////////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op   = ALU_PASS_B;
    use_imm  = 1'b0;
    write_en = 1'b1;
    dest_rd  = 1'b1;
    case (opcode)
      OP_ADD:  alu_op = ALU_ADD;
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_SLT:  alu_op = ALU_SLT;
      OP_SLL:  alu_op = ALU_SLL;
      OP_ADDI: begin
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
        dest_rd = 1'b0;
      end
      OP_ORI: begin
        alu_op  = ALU_OR;
        use_imm = 1'b1;
        dest_rd = 1'b0;
      end
      OP_LI: begin
        use_imm = 1'b1;
        dest_rd = 1'b0;
      end
      default: write_en = 1'b0;
    endcase
  end

  assign dest = dest_rd ? rd : rt_addr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_valid <= 1'b0;
      id_write <= 1'b0;
    end else if (advance) begin
      id_valid <= head_valid;
      // writes to r0 are dropped here
      id_write <= write_en && (dest != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      id_alu_op  <= alu_op;
      id_use_imm <= use_imm;
      id_rs      <= rs_addr;
      id_rt      <= rt_addr;
      id_dest    <= dest;
      id_op_a    <= rs_data;
      id_op_b    <= rt_data;
      id_imm     <= imm_ext;
      id_shamt   <= head_instr[SHAMT_MSB:SHAMT_LSB];
    end
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             advance,
  input  logic                             id_valid,
  input  core_pkg::alu_op_t                id_alu_op,
  input  logic                             id_use_imm,
  input  logic                             id_write,
  input  core_pkg::reg_addr_t              id_rs,
  input  core_pkg::reg_addr_t              id_rt,
  input  core_pkg::reg_addr_t              id_dest,
  input  core_pkg::data_t                  id_op_a,
  input  core_pkg::data_t                  id_op_b,
  input  core_pkg::data_t                  id_imm,
  input  logic [core_pkg::SHAMT_WIDTH-1:0] id_shamt,
  output logic                             ex_valid,
  output logic                             ex_write,
  output core_pkg::reg_addr_t              ex_dest,
  output core_pkg::data_t                  ex_data
);
  import core_pkg::*;

  logic  fwd_ok;
  data_t src_a;
  data_t src_b;
  data_t op_b;
  data_t alu_result;

  ////////////////////////////////////////////////////////////////////
  // forwarding from the unretired result
  ////////////////////////////////////////////////////////////////////

  // ex_write is never set for r0, so r0 never forwards
  assign fwd_ok = ex_valid && ex_write;
  assign src_a  = (fwd_ok && (ex_dest == id_rs)) ? ex_data : id_op_a;
  assign src_b  = (fwd_ok && (ex_dest == id_rt)) ? ex_data : id_op_b;

  // immediate already zero-extended in decode
  assign op_b = id_use_imm ? id_imm : src_b;

  always_comb begin
    case (id_alu_op)
      ALU_ADD:  alu_result = src_a + op_b;
      ALU_SUB:  alu_result = src_a - op_b;
      ALU_AND:  alu_result = src_a & op_b;
      ALU_OR:   alu_result = src_a | op_b;
      ALU_XOR:  alu_result = src_a ^ op_b;
      ALU_SLT: begin
        alu_result = {{(DATA_WIDTH - 1){1'b0}}, ($signed(src_a) < $signed(op_b))};
      end
      ALU_SLL:  alu_result = op_b << id_shamt;
      default:  alu_result = op_b;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // execute register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
      ex_write <= 1'b0;
    end else if (advance) begin
      ex_valid <= id_valid;
      ex_write <= id_write;
    end
  end

  // no-ops and r0 targets retire with zero data
  always_ff @(posedge clk) begin
    if (advance) begin
      ex_dest <= id_dest;
      ex_data <= id_write ? alu_result : '0;
    end
  end

endmodule

/* src/result_stage.sv */
`timescale 1ns/1ps

module result_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ex_valid,
  input  logic                ex_write,
  input  core_pkg::reg_addr_t ex_dest,
  input  core_pkg::data_t     ex_data,
  input  logic                out_credit,
  output logic                advance,
  output logic                out_valid,
  output logic                out_write,
  output core_pkg::reg_addr_t out_dest,
  output core_pkg::data_t     out_data,
  output logic                wr_en,
  output core_pkg::reg_addr_t wr_addr,
  output core_pkg::data_t     wr_data
);
  import core_pkg::*;

  logic [OUT_CNT_WIDTH-1:0] credit_cnt;
  logic                     has_credit;

  assign has_credit = (credit_cnt != '0);

  // pipeline moves when execute is empty or its result can leave
  assign advance = !ex_valid || has_credit;

  assign out_valid = ex_valid && advance;
  assign out_write = out_valid && ex_write;
  assign out_dest  = ex_dest;
  assign out_data  = ex_data;

  // retirement, in the same cycle as the emit
  assign wr_en   = out_write;
  assign wr_addr = ex_dest;
  assign wr_data = ex_data;

  // returned credits usable from the next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= OUT_CNT_WIDTH'(OUT_CREDITS);
    end else begin
      case ({out_valid, out_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

/* src/exec_core.sv */
`timescale 1ns/1ps

module exec_core (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_valid,
  input  core_pkg::instr_t    in_instr,
  output logic                in_credit,
  output logic                out_valid,
  output logic                out_write,
  output core_pkg::reg_addr_t out_dest,
  output core_pkg::data_t     out_data,
  input  logic                out_credit
);
  import core_pkg::*;

  logic                   advance;
  logic                   head_valid;
  instr_t                 head_instr;
  reg_addr_t              rs_addr;
  reg_addr_t              rt_addr;
  data_t                  rs_data;
  data_t                  rt_data;
  logic                   wr_en;
  reg_addr_t              wr_addr;
  data_t                  wr_data;

  // decode register
  logic                   id_valid;
  alu_op_t                id_alu_op;
  logic                   id_use_imm;
  logic                   id_write;
  reg_addr_t              id_rs;
  reg_addr_t              id_rt;
  reg_addr_t              id_dest;
  data_t                  id_op_a;
  data_t                  id_op_b;
  data_t                  id_imm;
  logic [SHAMT_WIDTH-1:0] id_shamt;

  // execute register
  logic                   ex_valid;
  logic                   ex_write;
  reg_addr_t              ex_dest;
  data_t                  ex_data;

  instr_queue u_queue (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_instr(in_instr),
    .advance(advance), .head_valid(head_valid), .head_instr(head_instr),
    .in_credit(in_credit)
  );

  register_file u_regfile (
    .clk(clk), .arst_n(arst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
    .rs_data(rs_data), .rt_data(rt_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  decode_stage u_decode (
    .clk(clk), .arst_n(arst_n), .advance(advance),
    .head_valid(head_valid), .head_instr(head_instr),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
    .id_valid(id_valid), .id_alu_op(id_alu_op), .id_use_imm(id_use_imm),
    .id_write(id_write), .id_rs(id_rs), .id_rt(id_rt), .id_dest(id_dest),
    .id_op_a(id_op_a), .id_op_b(id_op_b), .id_imm(id_imm), .id_shamt(id_shamt)
  );

  execute_stage u_execute (
    .clk(clk), .arst_n(arst_n), .advance(advance),
    .id_valid(id_valid), .id_alu_op(id_alu_op), .id_use_imm(id_use_imm),
    .id_write(id_write), .id_rs(id_rs), .id_rt(id_rt), .id_dest(id_dest),
    .id_op_a(id_op_a), .id_op_b(id_op_b), .id_imm(id_imm), .id_shamt(id_shamt),
    .ex_valid(ex_valid), .ex_write(ex_write), .ex_dest(ex_dest), .ex_data(ex_data)
  );

  result_stage u_result (
    .clk(clk), .arst_n(arst_n),
    .ex_valid(ex_valid), .ex_write(ex_write), .ex_dest(ex_dest), .ex_data(ex_data),
    .out_credit(out_credit), .advance(advance),
    .out_valid(out_valid), .out_write(out_write), .out_dest(out_dest), .out_data(out_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

endmodule

/* verif/tb_exec_core.sv */
`timescale 1ns/1ps

module tb_exec_core;
  import core_pkg::*;

  // instruction counts of the tests in run order
  localparam int TOTAL_INSTR     = 19 + 16 + 4 + 6 + 12;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 20 + 200;
  localparam int DRAIN_LIMIT     = 200;
  localparam int KIND_WRITE      = 0;
  localparam int KIND_R0         = 1;
  localparam int KIND_NOOP       = 2;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  instr_t    in_instr;
  logic      in_credit;
  logic      out_valid;
  logic      out_write;
  reg_addr_t out_dest;
  data_t     out_data;
  logic      out_credit;

  data_t     model_regs [NUM_REGS];
  int        exp_kind [$];
  logic      exp_write [$];
  reg_addr_t exp_dest [$];
  data_t     exp_data [$];
  int        up_credits;
  int        sent_count;
  int        out_count;
  int        owed;
  int        grant;
  bit        hold_output;
  int        checks_passed;
  int        checks_failed;

  exec_core UUT (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_instr(in_instr),
    .in_credit(in_credit), .out_valid(out_valid), .out_write(out_write),
    .out_dest(out_dest), .out_data(out_data), .out_credit(out_credit)
  );

  always #4 clk = ~clk;

  ///////////////////////////////////////////////////////////////////////
  // compare tasks
  ///////////////////////////////////////////////////////////////////////

  task automatic compare_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s = %h, expected %h", $time, name, got, exp);
      checks_failed++;
    end else begin
      checks_passed++;
    end
  endtask

  task automatic compare_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s = %0d, expected %0d", $time, name, got, exp);
      checks_failed++;
    end else begin
      checks_passed++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s = %b, expected %b", $time, name, got, exp);
      checks_failed++;
    end else begin
      checks_passed++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("at %0t: %s", $time, msg);
    checks_failed++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, checks_failed - errs_before);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // instruction builders and reference model
  ///////////////////////////////////////////////////////////////////////

  function automatic instr_t make_rtype(input logic [5:0] op, input reg_addr_t rd,
                                        input reg_addr_t rs, input reg_addr_t rt,
                                        input logic [SHAMT_WIDTH-1:0] shamt);
    instr_t ins;
    ins = '0;
    ins[OPCODE_MSB:OPCODE_LSB] = op;
    ins[RS_MSB:RS_LSB]         = rs;
    ins[RT_MSB:RT_LSB]         = rt;
    ins[RD_MSB:RD_LSB]         = rd;
    ins[SHAMT_MSB:SHAMT_LSB]   = shamt;
    return ins;
  endfunction

  function automatic instr_t make_itype(input logic [5:0] op, input reg_addr_t rt,
                                        input reg_addr_t rs, input logic [IMM_WIDTH-1:0] imm);
    instr_t ins;
    ins = '0;
    ins[OPCODE_MSB:OPCODE_LSB] = op;
    ins[RS_MSB:RS_LSB]         = rs;
    ins[RT_MSB:RT_LSB]         = rt;
    ins[IMM_MSB:IMM_LSB]       = imm;
    return ins;
  endfunction

  task automatic expect_instr(input instr_t ins);
    logic [5:0] op;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  dest;
    data_t      a;
    data_t      b;
    data_t      imm;
    data_t      res;
    int         kind;
    op   = ins[OPCODE_MSB:OPCODE_LSB];
    rs   = ins[RS_MSB:RS_LSB];
    rt   = ins[RT_MSB:RT_LSB];
    dest = ins[RD_MSB:RD_LSB];
    a    = model_regs[rs];
    b    = model_regs[rt];
    imm  = {{(DATA_WIDTH - IMM_WIDTH){1'b0}}, ins[IMM_MSB:IMM_LSB]};
    res  = '0;
    kind = KIND_WRITE;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLT:  res = data_t'($signed(a) < $signed(b));
      OP_SLL:  res = b << ins[SHAMT_MSB:SHAMT_LSB];
      OP_ADDI: begin
        dest = rt;
        res  = a + imm;
      end
      OP_ORI: begin
        dest = rt;
        res  = a | imm;
      end
      OP_LI: begin
        dest = rt;
        res  = imm;
      end
      default: kind = KIND_NOOP;
    endcase
    if (kind == KIND_WRITE && dest == '0) kind = KIND_R0;
    if (kind == KIND_WRITE) model_regs[dest] = res;
    exp_kind.push_back(kind);
    exp_write.push_back(kind == KIND_WRITE);
    exp_dest.push_back(dest);
    exp_data.push_back((kind == KIND_NOOP) ? '0 : res);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // upstream and downstream agents
  ///////////////////////////////////////////////////////////////////////

  // back to back while credits last
  task automatic send_instr(input instr_t ins);
    @(posedge clk);
    #1;
    while (up_credits == 0) begin
      in_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_instr = ins;
    up_credits--;
    sent_count++;
    expect_instr(ins);
  endtask

  task automatic end_burst();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic set_hold(input bit h);
    @(negedge clk);
    hold_output = h;
    grant       = 0;
  endtask

  task automatic grant_credit();
    @(negedge clk);
    grant++;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_kind.size() != 0 || owed != 0) && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_kind.size() != 0) report_problem("results still missing after the drain limit");
  endtask

  // consumed results go back as credits unless output is held
  always @(posedge clk) begin
    #1;
    if (owed > 0 && (!hold_output || grant > 0)) begin
      out_credit = 1'b1;
      owed--;
      if (hold_output) grant--;
    end else begin
      out_credit = 1'b0;
    end
  end

  always @(negedge clk) begin : link_monitor
    int kind;
    if (arst_n) begin
      if (in_credit) begin
        up_credits++;
        if (up_credits > QUEUE_DEPTH) report_problem("upstream holds more credits than queue depth");
      end
      if (out_valid) begin
        out_count++;
        owed++;
        if (exp_kind.size() == 0) begin
          report_problem("result emitted with no instruction outstanding");
        end else begin
          kind = exp_kind.pop_front();
          compare_flag("out_write", out_write, exp_write.pop_front());
          if (kind != KIND_NOOP) compare_reg("out_dest", out_dest, exp_dest[0]);
          if (kind != KIND_R0) compare_data("out_data", out_data, exp_data[0]);
          void'(exp_dest.pop_front());
          void'(exp_data.pop_front());
        end
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // tests
  ///////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int errs;
    errs = checks_failed;
    repeat (10) begin
      @(negedge clk);
      compare_flag("out_valid", out_valid, 1'b0);
      compare_flag("in_credit", in_credit, 1'b0);
    end
    report_test("reset_state", errs);
  endtask

  task automatic load_reg(input reg_addr_t r, input data_t val);
    send_instr(make_itype(OP_LI, r, 5'd0, val[31:16]));
    send_instr(make_rtype(OP_SLL, r, 5'd0, r, 5'd16));
    send_instr(make_itype(OP_ORI, r, r, val[15:0]));
  endtask

  task automatic test_every_opcode();
    int errs;
    int i;
    errs = checks_failed;
    load_reg(5'd1, data_t'($urandom));
    load_reg(5'd2, data_t'($urandom));
    for (i = 0; i <= 6; i++) begin
      send_instr(make_rtype(6'(i), reg_addr_t'(3 + i), 5'd1, 5'd2, 5'($urandom)));
    end
    send_instr(make_itype(OP_ADDI, 5'd10, 5'd1, 16'($urandom)));
    send_instr(make_itype(OP_ORI, 5'd11, 5'd1, 16'($urandom)));
    send_instr(make_itype(OP_LI, 5'd12, 5'd0, 16'($urandom)));
    // undefined opcodes
    send_instr(instr_t'({6'd7, 26'($urandom)}));
    send_instr(instr_t'({6'd11, 26'($urandom)}));
    send_instr(instr_t'({6'd63, 26'($urandom)}));
    end_burst();
    wait_drain();
    report_test("every_opcode", errs);
  endtask

  task automatic test_dependencies();
    int         errs;
    int         i;
    reg_addr_t  prev;
    reg_addr_t  prev2;
    reg_addr_t  dst;
    logic [5:0] op;
    errs  = checks_failed;
    prev  = 5'd1;
    prev2 = 5'd2;
    for (i = 0; i < 16; i++) begin
      dst = reg_addr_t'(13 + i % 4);
      op  = 6'($urandom % 7);
      if (i % 4 == 3) begin
        send_instr(make_itype(OP_ADDI, dst, prev, 16'($urandom)));
      end else if (i % 3 == 0) begin
        send_instr(make_rtype(op, dst, prev, prev2, 5'($urandom)));
      end else if (i % 3 == 1) begin
        send_instr(make_rtype(op, dst, prev2, prev, 5'($urandom)));
      end else begin
        send_instr(make_rtype(op, dst, prev, prev, 5'($urandom)));
      end
      prev2 = prev;
      prev  = dst;
    end
    end_burst();
    wait_drain();
    report_test("dependencies", errs);
  endtask

  task automatic test_r0_dest();
    int errs;
    errs = checks_failed;
    send_instr(make_itype(OP_ADDI, 5'd0, 5'd1, 16'h0055));
    send_instr(make_rtype(OP_ADD, 5'd0, 5'd1, 5'd2, 5'd0));
    // r0 read right behind an r0 write
    send_instr(make_rtype(OP_ADD, 5'd16, 5'd0, 5'd2, 5'd0));
    send_instr(make_rtype(OP_OR, 5'd17, 5'd0, 5'd0, 5'd0));
    end_burst();
    wait_drain();
    report_test("r0_dest", errs);
  endtask

  task automatic test_output_backpressure();
    int errs;
    int i;
    int start;
    int prev;
    errs = checks_failed;
    set_hold(1'b1);
    start = out_count;
    for (i = 0; i < 6; i++) begin
      send_instr(make_itype(OP_ADDI, 5'd18, 5'd18, 16'($urandom)));
    end
    end_burst();
    wait_cycles(20);
    if (out_count - start != OUT_CREDITS) report_problem("wrong result count with no credits returned");
    for (i = OUT_CREDITS; i < 6; i++) begin
      prev = out_count;
      grant_credit();
      wait_cycles(8);
      if (out_count != prev + 1) report_problem("one returned credit did not release one result");
    end
    set_hold(1'b0);
    wait_drain();
    report_test("output_backpressure", errs);
  endtask

  task automatic test_input_credits();
    int errs;
    int i;
    int start;
    errs = checks_failed;
    set_hold(1'b1);
    start = sent_count;
    fork
      begin
        for (i = 0; i < 12; i++) begin
          send_instr(make_rtype(OP_ADD, reg_addr_t'(20 + i % 4), 5'd1,
                                reg_addr_t'(20 + (i + 3) % 4), 5'd0));
        end
        end_burst();
      end
      begin
        wait_cycles(30);
        // queue entries, decode and execute registers, emitted results
        if (sent_count - start != QUEUE_DEPTH + 2 + OUT_CREDITS) begin
          report_problem("upstream sent a wrong number of instructions while output was blocked");
        end
        if (up_credits != 0) report_problem("upstream still holds credits while output is blocked");
        set_hold(1'b0);
      end
    join
    wait_drain();
    report_test("input_credits", errs);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ///////////////////////////////////////////////////////////////////////

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h946a69b5));
    clk           = 1'b0;
    arst_n        = 1'b0;
    in_valid      = 1'b0;
    in_instr      = '0;
    out_credit    = 1'b0;
    up_credits    = QUEUE_DEPTH;
    sent_count    = 0;
    out_count     = 0;
    owed          = 0;
    grant         = 0;
    hold_output   = 1'b0;
    checks_passed = 0;
    checks_failed = 0;
    for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset_state();
    test_every_opcode();
    test_dependencies();
    test_r0_dest();
    test_output_backpressure();
    test_input_credits();
    wait_cycles(5);
    if (up_credits != QUEUE_DEPTH) report_problem("upstream did not get all credits back");
    $display("checks passed: %0d, checks failed: %0d", checks_passed, checks_failed);
    if (checks_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* build.f */
src/core_pkg.sv
src/instr_queue.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/exec_core.sv
verif/tb_exec_core.sv
